/* include/alu_params.svh */
// Widths and depths for the ALU node; data width must hold the opcode field, buffer depth >= 1
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////////////////////

// Token payload width
`define ALU_DATA_WIDTH 32

// Opcode field in the low bits of the instruction word
`define ALU_OPCODE_WIDTH 4

// Low bits of operand B used as shift or rotate amount
`define ALU_SHIFT_WIDTH 5

// Entries per operand FIFO
`define ALU_BUFFER_DEPTH 4

`endif

/* verilog/aluPkg.sv */
// Token, instruction and state types; opcodes 10 to 15 are unused and produce a zero result
`include "alu_params.svh"

package aluPkg;

	////////////////////////////////////////////////////////////////////////////
	// Forward token
	////////////////////////////////////////////////////////////////////////////

	// Same layout on every link, 34 bits with the default data width
	typedef struct packed {
		logic valid;
		logic last;
		logic [`ALU_DATA_WIDTH-1:0] data;
	} token_t;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [`ALU_OPCODE_WIDTH-1:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opMul = 4'd2,
		opAnd = 4'd3,
		opOr = 4'd4,
		opXor = 4'd5,
		opShl = 4'd6,
		opShr = 4'd7,
		opSra = 4'd8,
		opRotl = 4'd9
	} opcode_e;

	// Overlays the data word of the first A token
	typedef struct packed {
		logic [`ALU_DATA_WIDTH-`ALU_OPCODE_WIDTH-1:0] reserved;
		opcode_e opcode;
	} instruction_t;

	// Configuration lifecycle of the node
	typedef enum logic [1:0] {
		awaitInstruction = 2'd0,
		streaming = 2'd1,
		draining = 2'd2
	} configState_e;

endpackage

/* verilog/configStage.sv */
// Source A carries one instruction then operands; after a last operand A stalls until release
`timescale 1ns/100ps

module configStage (
	input logic clock,
	input logic reset,
	input aluPkg::token_t source,
	output logic sourceStall,
	output aluPkg::token_t operand,
	input logic operandStall,
	input logic releasePulse,
	output aluPkg::opcode_e opcode,
	output logic configured
);

	aluPkg::configState_e state;
	aluPkg::instruction_t instruction;
	logic loadInstruction;
	logic passLast;

	////////////////////////////////////////////////////////////////////////////
	// Source steering
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		operand = source;
		operand.valid = 1'b0;
		sourceStall = 1'b0;
		loadInstruction = 1'b0;
		case (state)
			aluPkg::awaitInstruction: begin
				// Instruction register is always ready
				loadInstruction = source.valid;
			end
			aluPkg::streaming: begin
				operand.valid = source.valid;
				sourceStall = operandStall;
			end
			default: begin
				// Hold A back until the last result has left
				sourceStall = 1'b1;
			end
		endcase
	end

	assign passLast = operand.valid & operand.last & ~operandStall;

	////////////////////////////////////////////////////////////////////////////
	// State and instruction register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= aluPkg::awaitInstruction;
		end else begin
			case (state)
				aluPkg::awaitInstruction: begin
					if (loadInstruction) begin
						state <= aluPkg::streaming;
					end
				end
				aluPkg::streaming: begin
					if (passLast) begin
						state <= aluPkg::draining;
					end
				end
				default: begin
					if (releasePulse) begin
						state <= aluPkg::awaitInstruction;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			instruction <= '0;
		end else if (loadInstruction) begin
			instruction <= source.data;
		end
	end

	assign opcode = instruction.opcode;
	assign configured = (state != aluPkg::awaitInstruction);

	// Execute only releases after a last operand went through here
	releaseNotIdle: assert property (@(posedge clock) disable iff (reset)
		releasePulse |-> state != aluPkg::awaitInstruction);

endmodule

/* verilog/operandBuffer.sv */
// Registered FIFO for one operand stream; stall means full, pop is ignored when empty
`timescale 1ns/100ps

module operandBuffer #(
	parameter int depth = 4
) (
	input logic clock,
	input logic reset,
	input aluPkg::token_t in,
	output logic inStall,
	output aluPkg::token_t head,
	input logic pop
);

	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int countWidth = $clog2(depth + 1);
	localparam logic [ptrWidth-1:0] lastIndex = ptrWidth'(depth - 1);
	localparam logic [countWidth-1:0] fullCount = countWidth'(depth);

	aluPkg::token_t storage [depth];
	logic [ptrWidth-1:0] writePtr;
	logic [ptrWidth-1:0] readPtr;
	logic [countWidth-1:0] count;
	logic push;
	logic popEn;

	assign inStall = (count == fullCount);
	assign push = in.valid & ~inStall;
	assign popEn = pop & head.valid;

	// Entries hold payload only
	always_ff @(posedge clock) begin
		if (push) begin
			storage[writePtr] <= in;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				writePtr <= (writePtr == lastIndex) ? '0 : writePtr + 1'b1;
			end
			if (popEn) begin
				readPtr <= (readPtr == lastIndex) ? '0 : readPtr + 1'b1;
			end
			case ({push, popEn})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_comb begin
		head = storage[readPtr];
		head.valid = (count != '0);
	end

	// A token offered to a full buffer stays put until it is taken
	heldWhileFull: assert property (@(posedge clock) disable iff (reset)
		in.valid && inStall |=> in.valid && $stable(in.data) && $stable(in.last));

	// Consumer only pops a valid head
	noPopWhenEmpty: assert property (@(posedge clock) disable iff (reset)
		pop |-> head.valid);

endmodule

/* verilog/executeStage.sv */
// Pops both heads together when configured; operand B last is ignored, streams are equal length
`timescale 1ns/100ps
`include "alu_params.svh"

module executeStage (
	input logic clock,
	input logic reset,
	input aluPkg::token_t operandA,
	input aluPkg::token_t operandB,
	output logic popA,
	output logic popB,
	input aluPkg::opcode_e opcode,
	input logic configured,
	output aluPkg::token_t result,
	input logic resultStall,
	output logic releasePulse
);

	localparam int dataWidth = `ALU_DATA_WIDTH;

	logic fire;
	logic resultOpen;
	logic [`ALU_SHIFT_WIDTH-1:0] shiftAmount;
	logic [2*dataWidth-1:0] rotateWide;
	logic [dataWidth-1:0] aluOut;
	logic resultValid;
	logic resultLast;
	logic [dataWidth-1:0] resultData;

	////////////////////////////////////////////////////////////////////////////
	// Join
	////////////////////////////////////////////////////////////////////////////

	// Register empty or leaving this cycle
	assign resultOpen = ~resultValid | ~resultStall;
	assign fire = configured & operandA.valid & operandB.valid & resultOpen;
	assign popA = fire;
	assign popB = fire;

	////////////////////////////////////////////////////////////////////////////
	// Operation
	////////////////////////////////////////////////////////////////////////////

	assign shiftAmount = operandB.data[`ALU_SHIFT_WIDTH-1:0];

	// Upper half of the doubled word is the left rotation
	assign rotateWide = {operandA.data, operandA.data} << shiftAmount;

	always_comb begin
		case (opcode)
			aluPkg::opAdd: aluOut = operandA.data + operandB.data;
			aluPkg::opSub: aluOut = operandA.data - operandB.data;
			aluPkg::opMul: aluOut = operandA.data * operandB.data;
			aluPkg::opAnd: aluOut = operandA.data & operandB.data;
			aluPkg::opOr: aluOut = operandA.data | operandB.data;
			aluPkg::opXor: aluOut = operandA.data ^ operandB.data;
			aluPkg::opShl: aluOut = operandA.data << shiftAmount;
			aluPkg::opShr: aluOut = operandA.data >> shiftAmount;
			aluPkg::opSra: aluOut = $unsigned($signed(operandA.data) >>> shiftAmount);
			aluPkg::opRotl: aluOut = rotateWide[2*dataWidth-1:dataWidth];
			default: aluOut = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Result register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			resultValid <= 1'b0;
		end else if (resultOpen) begin
			resultValid <= fire;
		end
	end

	always_ff @(posedge clock) begin
		if (fire) begin
			resultLast <= operandA.last;
			resultData <= aluOut;
		end
	end

	always_comb begin
		result.valid = resultValid;
		result.last = resultLast;
		result.data = resultData;
	end

	// End of stream handed downstream
	assign releasePulse = resultValid & resultLast & ~resultStall;

	resultHeld: assert property (@(posedge clock) disable iff (reset)
		result.valid && resultStall |=> result.valid && $stable(result.data)
		&& $stable(result.last));

endmodule

/* verilog/aluNode.sv */
// Dataflow ALU node; first A token after reset or release is the instruction, B is operands only
`timescale 1ns/100ps
`include "alu_params.svh"

module aluNode (
	input logic clock,
	input logic reset,
	input aluPkg::token_t sourceA,
	input aluPkg::token_t sourceB,
	output logic sourceAStall,
	output logic sourceBStall,
	output aluPkg::token_t result,
	input logic resultStall
);

	aluPkg::token_t streamA;
	logic streamAStall;
	aluPkg::token_t headA;
	aluPkg::token_t headB;
	logic popA;
	logic popB;
	logic releasePulse;
	logic configured;
	aluPkg::opcode_e opcode;

	////////////////////////////////////////////////////////////////////////////
	// Source A steering
	////////////////////////////////////////////////////////////////////////////

	configStage configUnit (
		.clock(clock),
		.reset(reset),
		.source(sourceA),
		.sourceStall(sourceAStall),
		.operand(streamA),
		.operandStall(streamAStall),
		.releasePulse(releasePulse),
		.opcode(opcode),
		.configured(configured)
	);

	////////////////////////////////////////////////////////////////////////////
	// Operand buffers
	////////////////////////////////////////////////////////////////////////////

	operandBuffer #(
		.depth(`ALU_BUFFER_DEPTH)
	) bufferA (
		.clock(clock),
		.reset(reset),
		.in(streamA),
		.inStall(streamAStall),
		.head(headA),
		.pop(popA)
	);

	// B skips steering and goes straight in
	operandBuffer #(
		.depth(`ALU_BUFFER_DEPTH)
	) bufferB (
		.clock(clock),
		.reset(reset),
		.in(sourceB),
		.inStall(sourceBStall),
		.head(headB),
		.pop(popB)
	);

	executeStage execute (
		.clock(clock),
		.reset(reset),
		.operandA(headA),
		.operandB(headB),
		.popA(popA),
		.popB(popB),
		.opcode(opcode),
		.configured(configured),
		.result(result),
		.resultStall(resultStall),
		.releasePulse(releasePulse)
	);

endmodule

/* test/aluNodeTb.sv */
// Directed tests of the ALU node; B skew tests assume 4-deep operand buffers, watchdog bounds the run
`timescale 1ns/100ps
`include "alu_params.svh"

module aluNodeTb;

	localparam int clockPeriod = 10;
	localparam int dataWidth = `ALU_DATA_WIDTH;
	// Tokens and held cycles per test, summed
	localparam int testLength = 1 + 30 + 14 + 17 + 5 + 12;

	logic clock;
	logic reset;
	aluPkg::token_t sourceA;
	aluPkg::token_t sourceB;
	logic sourceAStall;
	logic sourceBStall;
	aluPkg::token_t result;
	logic resultStall;

	int seed;
	int errorCount;
	int testsRun;
	int testsFailed;
	aluPkg::token_t queueA[$];
	aluPkg::token_t queueB[$];
	aluPkg::token_t expQ[$];

	aluNode UUT (
		.clock(clock),
		.reset(reset),
		.sourceA(sourceA),
		.sourceB(sourceB),
		.sourceAStall(sourceAStall),
		.sourceBStall(sourceBStall),
		.result(result),
		.resultStall(resultStall)
	);

	always #(clockPeriod / 2) clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [dataWidth-1:0] expectedValue(input aluPkg::opcode_e op,
			input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		int shift;
		logic [dataWidth-1:0] signFill;
		shift = int'(b[`ALU_SHIFT_WIDTH-1:0]);
		// Vacated top bits copy the sign bit
		signFill = a[dataWidth-1] ? ~({dataWidth{1'b1}} >> shift) : '0;
		case (op)
			aluPkg::opAdd: return a + b;
			aluPkg::opSub: return a - b;
			aluPkg::opMul: return a * b;
			aluPkg::opAnd: return a & b;
			aluPkg::opOr: return a | b;
			aluPkg::opXor: return a ^ b;
			aluPkg::opShl: return a << shift;
			aluPkg::opShr: return a >> shift;
			aluPkg::opSra: return (a >> shift) | signFill;
			// Bits pushed out on the left come back in on the right
			aluPkg::opRotl: return (a << shift) | (a >> (dataWidth - shift));
			default: return '0;
		endcase
	endfunction

	function automatic aluPkg::token_t makeToken(input logic last,
			input logic [dataWidth-1:0] data);
		aluPkg::token_t tok;
		tok.valid = 1'b1;
		tok.last = last;
		tok.data = data;
		return tok;
	endfunction

	task automatic compareToken(input string name, input aluPkg::token_t actual,
			input aluPkg::token_t expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s expected valid=%b last=%b data=%h, got valid=%b last=%b data=%h",
				$time, name, expected.valid, expected.last, expected.data,
				actual.valid, actual.last, actual.data);
			errorCount++;
		end
	endtask

	task automatic compareBit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t: %s expected %b, got %b", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testsRun++;
		if (errorCount == errorsBefore) begin
			$display("Test %s: ok", name);
		end else begin
			testsFailed++;
			$display("Test %s: failed with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stream building and drivers
	////////////////////////////////////////////////////////////////////////////

	task automatic queueInstruction(input aluPkg::opcode_e op);
		aluPkg::instruction_t word;
		word = '0;
		word.opcode = op;
		queueA.push_back(makeToken(1'b0, word));
	endtask

	task automatic queuePair(input aluPkg::opcode_e op, input logic [dataWidth-1:0] a,
			input logic [dataWidth-1:0] b, input logic last);
		queueA.push_back(makeToken(last, a));
		queueB.push_back(makeToken(last, b));
		expQ.push_back(makeToken(last, expectedValue(op, a, b)));
	endtask

	task automatic queueRandomPair(input aluPkg::opcode_e op, input logic last);
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		a = $random(seed);
		b = $random(seed);
		queuePair(op, a, b, last);
	endtask

	// Drivers start and return 1 ns after a rising edge
	task automatic driveStreamA();
		logic accepted;
		while (queueA.size() > 0) begin
			sourceA = queueA.pop_front();
			accepted = 1'b0;
			while (!accepted) begin
				@(negedge clock);
				accepted = ~sourceAStall;
				@(posedge clock);
				#1;
			end
		end
		sourceA = '0;
	endtask

	task automatic driveStreamB();
		logic accepted;
		while (queueB.size() > 0) begin
			sourceB = queueB.pop_front();
			accepted = 1'b0;
			while (!accepted) begin
				@(negedge clock);
				accepted = ~sourceBStall;
				@(posedge clock);
				#1;
			end
		end
		sourceB = '0;
	endtask

	task automatic collectResults(input int count, input logic randomStall);
		aluPkg::token_t held;
		logic heldPending;
		logic [31:0] roll;
		int got;
		got = 0;
		heldPending = 1'b0;
		while (got < count) begin
			roll = $random(seed);
			resultStall = randomStall & roll[0];
			@(negedge clock);
			if (heldPending) begin
				compareToken("result held", result, held);
			end
			heldPending = 1'b0;
			if (result.valid && resultStall) begin
				held = result;
				heldPending = 1'b1;
			end else if (result.valid) begin
				compareToken("result", result, expQ.pop_front());
				got++;
			end
			@(posedge clock);
			#1;
		end
		resultStall = 1'b0;
		// Nothing may follow the last result of the stream
		@(negedge clock);
		compareBit("result.valid", result.valid, 1'b0);
		@(posedge clock);
		#1;
	endtask

	task automatic runStream(input int aDelay, input logic randomStall);
		int expected;
		expected = expQ.size();
		fork
			begin
				repeat (aDelay) begin
					@(posedge clock);
					#1;
				end
				driveStreamA();
			end
			driveStreamB();
			collectResults(expected, randomStall);
		join
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic testResetState();
		int errorsBefore;
		errorsBefore = errorCount;
		@(negedge clock);
		compareBit("result.valid", result.valid, 1'b0);
		compareBit("sourceAStall", sourceAStall, 1'b0);
		compareBit("sourceBStall", sourceBStall, 1'b0);
		@(posedge clock);
		#1;
		finishTest("reset state", errorsBefore);
	endtask

	task automatic testEachOpcode();
		int errorsBefore;
		errorsBefore = errorCount;
		for (int i = 0; i < 10; i++) begin
			queueInstruction(aluPkg::opcode_e'(i[`ALU_OPCODE_WIDTH-1:0]));
			queueRandomPair(aluPkg::opcode_e'(i[`ALU_OPCODE_WIDTH-1:0]), 1'b1);
			runStream(0, 1'b0);
		end
		finishTest("each opcode", errorsBefore);
	endtask

	task automatic testReconfigure();
		int errorsBefore;
		errorsBefore = errorCount;
		queueInstruction(aluPkg::opAdd);
		for (int i = 0; i < 8; i++) begin
			queueRandomPair(aluPkg::opAdd, i == 7);
		end
		// Second instruction waits on A until the add stream is released
		queueInstruction(aluPkg::opXor);
		for (int i = 0; i < 4; i++) begin
			queueRandomPair(aluPkg::opXor, i == 3);
		end
		runStream(0, 1'b0);
		finishTest("release and reconfigure", errorsBefore);
	endtask

	task automatic testBackPressure();
		int errorsBefore;
		errorsBefore = errorCount;
		queueInstruction(aluPkg::opMul);
		for (int i = 0; i < 16; i++) begin
			queueRandomPair(aluPkg::opMul, i == 15);
		end
		runStream(0, 1'b1);
		finishTest("random back-pressure", errorsBefore);
	endtask

	task automatic testEarlyB();
		int errorsBefore;
		errorsBefore = errorCount;
		queueInstruction(aluPkg::opSub);
		for (int i = 0; i < 4; i++) begin
			queueRandomPair(aluPkg::opSub, i == 3);
		end
		runStream(6, 1'b0);
		finishTest("B ahead of instruction", errorsBefore);
	endtask

	task automatic testHeldRelease();
		aluPkg::instruction_t word;
		aluPkg::token_t heldExpected;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		int errorsBefore;
		int waited;
		errorsBefore = errorCount;
		a = $random(seed);
		b = $random(seed);
		resultStall = 1'b1;
		queueInstruction(aluPkg::opAdd);
		queuePair(aluPkg::opAdd, a, b, 1'b1);
		heldExpected = expQ.pop_front();
		fork
			driveStreamA();
			driveStreamB();
		join
		waited = 0;
		@(negedge clock);
		while (!result.valid && waited < 20) begin
			@(negedge clock);
			waited++;
		end
		if (!result.valid) begin
			$display("ERROR at %0t: no result appeared while held", $time);
			errorCount++;
		end
		@(posedge clock);
		#1;
		word = '0;
		word.opcode = aluPkg::opXor;
		sourceA = makeToken(1'b0, word);
		repeat (4) begin
			@(negedge clock);
			compareBit("sourceAStall", sourceAStall, 1'b1);
			compareToken("result held", result, heldExpected);
			@(posedge clock);
			#1;
		end
		resultStall = 1'b0;
		@(negedge clock);
		compareBit("sourceAStall", sourceAStall, 1'b1);
		compareToken("result", result, heldExpected);
		@(posedge clock);
		#1;
		@(negedge clock);
		compareBit("sourceAStall", sourceAStall, 1'b0);
		compareBit("result.valid", result.valid, 1'b0);
		@(posedge clock);
		#1;
		sourceA = '0;
		queuePair(aluPkg::opXor, a, b, 1'b1);
		runStream(0, 1'b0);
		finishTest("instruction behind held result", errorsBefore);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		sourceA = '0;
		sourceB = '0;
		resultStall = 1'b0;
		seed = 32'h397f946f;
		errorCount = 0;
		testsRun = 0;
		testsFailed = 0;
		repeat (5) begin
			@(posedge clock);
		end
		#1;
		reset = 1'b0;
		testResetState();
		testEachOpcode();
		testReconfigure();
		testBackPressure();
		testEarlyB();
		testHeldRelease();
		$display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(testLength * 20 * clockPeriod);
		$display("Watchdog expired after %0d cycles with tests still running",
			testLength * 20);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* project.f */
+incdir+include
verilog/aluPkg.sv
verilog/configStage.sv
verilog/operandBuffer.sv
verilog/executeStage.sv
verilog/aluNode.sv
test/aluNodeTb.sv

/* run.sh */
#!/bin/sh
# Build the ALU node testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module aluNodeTb \
	-Mdir obj_dir -o aluNodeSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/aluNodeSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Simulation finished: PASS"; then
	exit 0
fi
exit 1
